/* fp_defines.svh */
// Single-precision format widths and the alignment shift limit for the adder
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Full operand word
`define FP_WORD_WIDTH 32

// Biased exponent field
`define FP_EXP_WIDTH 8

// Stored fraction field, hidden one excluded
`define FP_MAN_WIDTH 23

// Hidden one, fraction, then guard, round and sticky
`define FP_EXT_WIDTH 27

// Past this difference every bit of the smaller operand lands in sticky
`define FP_MAX_ALIGN 26

`endif

/* fpPkg.sv */
// Shared vector types and controller state encoding for the floating-point adder
`include "fp_defines.svh"

package fpPkg;

    // Sign, exponent and fraction in IEEE single-precision layout
    typedef logic [`FP_WORD_WIDTH-1:0] fpWordT;

    typedef logic [`FP_EXP_WIDTH-1:0] expT;

    // Mantissa with hidden one and three rounding bits
    typedef logic [`FP_EXT_WIDTH-1:0] extManT;

    // One extra bit on top for the carry out of an addition
    typedef logic [`FP_EXT_WIDTH:0] sumT;

    // Wide enough to hold the clamped exponent difference
    typedef logic [$clog2(`FP_MAX_ALIGN+1)-1:0] shiftCountT;

    typedef enum logic [2:0]
    {
        Idle,
        Load,
        Align,
        Add,
        Norm
    } addStateT;

endpackage

/* fpAddControl.sv */
// Adder FSM that sequences operand load, alignment, add and normalize, then pulses done
`timescale 1ns/1ns

module fpAddControl
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic countZero,
    output logic loadEn,
    output logic shiftEn,
    output logic addEn,
    output logic normEn,
    output logic done
);
    import fpPkg::*;

    addStateT state;
    addStateT nextState;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            state <= Idle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
            begin
                if (start)
                    nextState = Load;
            end
            // Count is already valid here, a zero difference skips alignment
            Load:
            begin
                nextState = countZero ? Add : Align;
            end
            Align:
            begin
                if (countZero)
                    nextState = Add;
            end
            Add:
                nextState = Norm;
            Norm:
                nextState = Idle;
            default:
                nextState = Idle;
        endcase
    end

    // Operands are captured on the start edge itself, starts while busy are dropped
    assign loadEn = (state == Idle) && start;

    // First shift overlaps the Load cycle so alignment costs N cycles in total
    assign shiftEn = ((state == Load) || (state == Align)) && !countZero;

    assign addEn = (state == Add);

    // Result register is written at the end of this cycle
    assign normEn = (state == Norm);
    assign done   = (state == Norm);

endmodule

/* alignCounter.sv */
// Alignment down-counter that times the right shifts of the smaller mantissa
`timescale 1ns/1ns

module alignCounter
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              loadEn,
    input  logic              shiftEn,
    input  fpPkg::shiftCountT loadCount,
    output logic              countZero
);
    import fpPkg::*;

    // Shifts still to be done
    shiftCountT count;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            count <= '0;
        else if (loadEn)
            count <= loadCount;
        else if (shiftEn && (count != '0))
            count <= count - 1'b1;
    end

    assign countZero = (count == '0);

endmodule

/* alignShifter.sv */
// Operand swap and alignment shifter that collects guard, round and sticky bits
`timescale 1ns/1ns
`include "fp_defines.svh"

module alignShifter
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              loadEn,
    input  logic              shiftEn,
    input  fpPkg::fpWordT     opA,
    input  fpPkg::fpWordT     opB,
    output fpPkg::shiftCountT loadCount,
    output fpPkg::extManT     largeMan,
    output fpPkg::extManT     smallMan,
    output fpPkg::expT        largeExp,
    output logic              largeSign,
    output logic              effSub
);
    import fpPkg::*;

    logic   aLarger;
    fpWordT bigOp;
    fpWordT littleOp;
    expT    expDiff;

    // Hidden one in front, rounding bits empty; zero stays zero
    function automatic extManT expand(input fpWordT op);
        expT exponent;
        exponent = op[`FP_WORD_WIDTH-2:`FP_MAN_WIDTH];
        if (exponent == '0)
            return '0;
        return {1'b1, op[`FP_MAN_WIDTH-1:0], 3'b000};
    endfunction

    // Exponent sits above fraction, so the raw bits compare as magnitudes
    assign aLarger  = opA[`FP_WORD_WIDTH-2:0] >= opB[`FP_WORD_WIDTH-2:0];
    assign bigOp    = aLarger ? opA : opB;
    assign littleOp = aLarger ? opB : opA;

    assign expDiff = bigOp[`FP_WORD_WIDTH-2:`FP_MAN_WIDTH]
                   - littleOp[`FP_WORD_WIDTH-2:`FP_MAN_WIDTH];

    assign loadCount = (expDiff > `FP_MAX_ALIGN) ? shiftCountT'(`FP_MAX_ALIGN)
                                                 : shiftCountT'(expDiff);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            largeMan  <= '0;
            smallMan  <= '0;
            largeExp  <= '0;
            largeSign <= 1'b0;
            effSub    <= 1'b0;
        end
        else if (loadEn)
        begin
            largeMan  <= expand(bigOp);
            smallMan  <= expand(littleOp);
            largeExp  <= bigOp[`FP_WORD_WIDTH-2:`FP_MAN_WIDTH];
            largeSign <= bigOp[`FP_WORD_WIDTH-1];
            effSub    <= opA[`FP_WORD_WIDTH-1] ^ opB[`FP_WORD_WIDTH-1];
        end
        // Bit falling off the bottom is kept in sticky
        else if (shiftEn)
            smallMan <= {1'b0, smallMan[`FP_EXT_WIDTH-1:2], smallMan[1] | smallMan[0]};
    end

endmodule

/* mantissaAdder.sv */
// Signed-magnitude add or subtract of the aligned mantissas into the sum register
`timescale 1ns/1ns

module mantissaAdder
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          addEn,
    input  fpPkg::extManT largeMan,
    input  fpPkg::extManT smallMan,
    input  fpPkg::expT    largeExp,
    input  logic          largeSign,
    input  logic          effSub,
    output fpPkg::sumT    sum,
    output fpPkg::expT    sumExp,
    output logic          sumSign
);
    import fpPkg::*;

    sumT rawSum;

    // Larger magnitude always comes first, so subtraction never goes negative
    always_comb
    begin
        if (effSub)
            rawSum = {1'b0, largeMan} - {1'b0, smallMan};
        else
            rawSum = {1'b0, largeMan} + {1'b0, smallMan};
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            sum     <= '0;
            sumExp  <= '0;
            sumSign <= 1'b0;
        end
        else if (addEn)
        begin
            sum     <= rawSum;
            sumExp  <= largeExp;
            // Exact cancellation comes out as +0
            sumSign <= largeSign & (|rawSum);
        end
    end

endmodule

/* normalize.sv */
// Normalize stage that shifts the raw sum, rounds to nearest-even and registers the result
`timescale 1ns/1ns
`include "fp_defines.svh"

module normalize
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          normEn,
    input  fpPkg::sumT    sum,
    input  fpPkg::expT    sumExp,
    input  logic          sumSign,
    output fpPkg::fpWordT result
);
    import fpPkg::*;

    extManT                   shifted;
    shiftCountT               leadZeros;
    logic [`FP_EXP_WIDTH+1:0] expWide;
    logic [`FP_EXP_WIDTH+1:0] expRound;
    logic [`FP_MAN_WIDTH+1:0] rounded;
    logic [`FP_MAN_WIDTH-1:0] fraction;
    logic                     roundUp;
    logic                     underflow;
    fpWordT                   nextResult;

    // Highest set bit wins since it is seen last
    function automatic shiftCountT countLeadZeros(input extManT value);
        shiftCountT zeros;
        zeros = shiftCountT'(`FP_EXT_WIDTH);
        for (int i = 0; i < `FP_EXT_WIDTH; i++)
        begin
            if (value[i])
                zeros = shiftCountT'(`FP_EXT_WIDTH - 1 - i);
        end
        return zeros;
    endfunction

    always_comb
    begin
        leadZeros = '0;
        if (sum[`FP_EXT_WIDTH])
        begin
            // Carry out, one step right with the lost bit kept in sticky
            shifted = {sum[`FP_EXT_WIDTH:2], sum[1] | sum[0]};
            expWide = {2'b00, sumExp} + 1'b1;
        end
        else
        begin
            leadZeros = countLeadZeros(sum[`FP_EXT_WIDTH-1:0]);
            shifted   = sum[`FP_EXT_WIDTH-1:0] << leadZeros;
            expWide   = {2'b00, sumExp} - leadZeros;
        end

        // Wrapped or zero exponent means the result is too small
        underflow = (expWide == '0) || expWide[`FP_EXP_WIDTH+1];

        // Guard set, then round, sticky or an odd LSB decides
        roundUp  = shifted[2] & (shifted[1] | shifted[0] | shifted[3]);
        rounded  = {1'b0, shifted[`FP_EXT_WIDTH-1:3]} + roundUp;
        expRound = expWide + rounded[`FP_MAN_WIDTH+1];
        fraction = rounded[`FP_MAN_WIDTH+1] ? rounded[`FP_MAN_WIDTH:1]
                                            : rounded[`FP_MAN_WIDTH-1:0];

        if (sum == '0)
            nextResult = '0;
        else if (underflow)
            nextResult = {sumSign, {(`FP_WORD_WIDTH-1){1'b0}}};
        else if (expRound >= {2'b00, {`FP_EXP_WIDTH{1'b1}}})
            nextResult = {sumSign, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
        else
            nextResult = {sumSign, expRound[`FP_EXP_WIDTH-1:0], fraction};
    end

    // Holds until the next operation finishes
    always_ff @(posedge clk)
    begin
        if (!rstN)
            result <= '0;
        else if (normEn)
            result <= nextResult;
    end

endmodule

/* fpAdder.sv */
// Single-precision floating-point adder top joining the FSM, counter and datapath stages
`timescale 1ns/1ns

module fpAdder
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  fpPkg::fpWordT opA,
    input  fpPkg::fpWordT opB,
    output fpPkg::fpWordT result,
    output logic          done
);
    import fpPkg::*;

    logic       loadEn;
    logic       shiftEn;
    logic       addEn;
    logic       normEn;
    logic       countZero;
    shiftCountT loadCount;
    extManT     largeMan;
    extManT     smallMan;
    expT        largeExp;
    logic       largeSign;
    logic       effSub;
    sumT        sum;
    expT        sumExp;
    logic       sumSign;

    fpAddControl uControl
    (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .countZero (countZero),
        .loadEn    (loadEn),
        .shiftEn   (shiftEn),
        .addEn     (addEn),
        .normEn    (normEn),
        .done      (done)
    );

    alignCounter uCounter
    (
        .clk       (clk),
        .rstN      (rstN),
        .loadEn    (loadEn),
        .shiftEn   (shiftEn),
        .loadCount (loadCount),
        .countZero (countZero)
    );

    alignShifter uShifter
    (
        .clk       (clk),
        .rstN      (rstN),
        .loadEn    (loadEn),
        .shiftEn   (shiftEn),
        .opA       (opA),
        .opB       (opB),
        .loadCount (loadCount),
        .largeMan  (largeMan),
        .smallMan  (smallMan),
        .largeExp  (largeExp),
        .largeSign (largeSign),
        .effSub    (effSub)
    );

    mantissaAdder uAdder
    (
        .clk       (clk),
        .rstN      (rstN),
        .addEn     (addEn),
        .largeMan  (largeMan),
        .smallMan  (smallMan),
        .largeExp  (largeExp),
        .largeSign (largeSign),
        .effSub    (effSub),
        .sum       (sum),
        .sumExp    (sumExp),
        .sumSign   (sumSign)
    );

    normalize uNormalize
    (
        .clk     (clk),
        .rstN    (rstN),
        .normEn  (normEn),
        .sum     (sum),
        .sumExp  (sumExp),
        .sumSign (sumSign),
        .result  (result)
    );

endmodule

/* fpAdder_asserts.sv */
// Concurrent checks on the adder's control strobes, bound into the top level
`timescale 1ns/1ns

module fpAdderAsserts
(
    input logic clk,
    input logic rstN,
    input logic loadEn,
    input logic done
);
    // Accepted operations that have not reached done yet
    int pending;
    int violations = 0;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pending <= 0;
        else
            pending <= pending + int'(loadEn) - int'(done);
    end

    doneLowAfterReset: assert property (@(posedge clk) !rstN |=> !done)
    else
    begin
        $error("done is high right after reset");
        violations++;
    end

    doneOneCycle: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        violations++;
    end

    // Longest alignment is the clamp limit plus three
    startGetsDone: assert property (@(posedge clk) disable iff (!rstN)
        loadEn |-> ##[3:29] done)
    else
    begin
        $error("accepted start was not followed by done");
        violations++;
    end

    doneNeedsStart: assert property (@(posedge clk) disable iff (!rstN)
        done |-> (pending == 1))
    else
    begin
        $error("done without exactly one outstanding operation");
        violations++;
    end

endmodule

/* fpAdderChecker.sv */
// Monitor that compares each adder result and its latency with the expected queue
`timescale 1ns/1ns

module fpAdderChecker
(
    input logic          clk,
    input logic          rstN,
    input logic          start,
    input fpPkg::fpWordT result,
    input logic          done
);
    import fpPkg::*;

    fpWordT expResults[$];
    int     expLatencies[$];
    fpWordT expected;
    int     latency;
    int     valueErrors = 0;
    int     latencyErrors = 0;
    int     protocolErrors = 0;
    int     checked = 0;
    int     cycle = 0;
    int     startCycle = 0;
    logic   resultPending = 1'b0;

    // Called by the stimulus before each start
    task automatic pushExpected(input fpWordT value, input int cycles);
        expResults.push_back(value);
        expLatencies.push_back(cycles);
    endtask

    task automatic finalReport(input int assertErrors, output int total);
        if (expResults.size() != 0)
        begin
            $display("ERROR: %0d operations never produced done", expResults.size());
            protocolErrors += expResults.size();
        end
        total = valueErrors + latencyErrors + protocolErrors + assertErrors;
        $display("checked %0d, errors: value %0d, latency %0d, protocol %0d, assertion %0d",
                 checked, valueErrors, latencyErrors, protocolErrors, assertErrors);
    endtask

    // Result register is written on the edge that ends done
    always @(negedge clk)
    begin
        cycle++;
        if (!rstN)
            resultPending = 1'b0;
        else
        begin
            if (start)
                startCycle = cycle;
            if (resultPending)
            begin
                if (result !== expected)
                begin
                    $display("mismatch result: expected 0x%08h, got 0x%08h, operation %0d",
                             expected, result, checked);
                    valueErrors++;
                end
                checked++;
                resultPending = 1'b0;
            end
            if (done)
            begin
                if (expResults.size() == 0)
                begin
                    $display("ERROR: done pulsed with no operation outstanding");
                    protocolErrors++;
                end
                else
                begin
                    expected = expResults.pop_front();
                    latency  = expLatencies.pop_front();
                    if (cycle - startCycle != latency)
                    begin
                        $display("ERROR: operation %0d took %0d cycles, expected %0d",
                                 checked, cycle - startCycle, latency);
                        latencyErrors++;
                    end
                    resultPending = 1'b1;
                end
            end
        end
    end

endmodule

/* fpAdderTb.sv */
// Testbench for the floating-point adder with seeded random operands and a reference model
`timescale 1ns/1ns
`include "fp_defines.svh"

module fpAdderTb;
    import fpPkg::*;

    localparam int numOps      = 300;
    localparam int resetCycles = 16;
    localparam int cyclesPerOp = 40;
    localparam int clockPeriod = 100;

    logic   clk = 1'b0;
    logic   rstN;
    logic   start;
    fpWordT opA;
    fpWordT opB;
    fpWordT result;
    logic   done;
    fpWordT nextA;
    fpWordT nextB;
    fpWordT expWord;
    int     expLatency;
    int     totalErrors;

    fpAdder DUT
    (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .opA    (opA),
        .opB    (opB),
        .result (result),
        .done   (done)
    );

    fpAdderChecker monitor
    (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .result (result),
        .done   (done)
    );

    bind fpAdder fpAdderAsserts asserts
    (
        .clk    (clk),
        .rstN   (rstN),
        .loadEn (loadEn),
        .done   (done)
    );

    always #(clockPeriod / 2) clk = ~clk;

    function automatic fpWordT makeOp(input logic sign, input int exponent);
        return {sign, exponent[7:0], 23'($urandom)};
    endfunction

    // Reference add from the format rules and the expected start to done latency
    task automatic modelAdd(input fpWordT a, input fpWordT b, output fpWordT res,
                            output int lat);
        fpWordT      big;
        fpWordT      little;
        int          shift;
        int          exponent;
        logic [31:0] bigMan;
        logic [31:0] smallMan;
        logic [31:0] total;
        logic        sticky;
        logic        roundUp;

        big    = (a[30:0] >= b[30:0]) ? a : b;
        little = (a[30:0] >= b[30:0]) ? b : a;
        shift  = big[30:23] - little[30:23];
        if (shift > `FP_MAX_ALIGN)
            shift = `FP_MAX_ALIGN;
        lat      = shift + 3;
        bigMan   = (big[30:23] == 0) ? 32'd0 : {5'b0, 1'b1, big[22:0], 3'b0};
        smallMan = (little[30:23] == 0) ? 32'd0 : {5'b0, 1'b1, little[22:0], 3'b0};
        // Bits shifted out collapse into sticky
        sticky   = (smallMan & ((32'd1 << shift) - 1)) != 0;
        smallMan = (smallMan >> shift) | sticky;
        total    = (a[31] == b[31]) ? bigMan + smallMan : bigMan - smallMan;
        exponent = big[30:23];
        if (total == 0)
            res = '0;
        else
        begin
            if (total[27])
            begin
                total = (total >> 1) | total[0];
                exponent++;
            end
            while (!total[26])
            begin
                total = total << 1;
                exponent--;
            end
            if (exponent <= 0)
                res = {big[31], 31'b0};
            else
            begin
                roundUp = total[2] && (total[1] || total[0] || total[3]);
                total   = (total >> 3) + roundUp;
                if (total[24])
                begin
                    total = total >> 1;
                    exponent++;
                end
                if (exponent >= 255)
                    res = {big[31], 8'hFF, 23'b0};
                else
                    res = {big[31], exponent[7:0], total[22:0]};
            end
        end
    endtask

    // Mix of random normals and corner cases
    task automatic pickOperands(output fpWordT a, output fpWordT b);
        int     kind;
        int     expA;
        fpWordT swap;

        kind = $urandom % 8;
        expA = 1 + $urandom % 254;
        a    = makeOp(1'($urandom), expA);
        case (kind)
            0: b = {1'($urandom), 31'b0};
            1: b = {1'($urandom), a[30:0]};
            2:
            begin
                expA = 40 + $urandom % 200;
                a    = makeOp(1'($urandom), expA);
                b    = makeOp(1'($urandom), expA - 26 - $urandom % 14);
            end
            3:
            begin
                a = makeOp(1'($urandom), 253 + $urandom % 2);
                b = makeOp(a[31], 253 + $urandom % 2);
            end
            4:
            begin
                a = makeOp(1'($urandom), 1 + $urandom % 3);
                b = {~a[31], a[30:0] ^ 31'($urandom % 64)};
            end
            5: b = {~a[31], a[30:0] ^ 31'($urandom % 4096)};
            default:
            begin
                expA = expA - 30 + $urandom % 61;
                b    = makeOp(1'($urandom), (expA < 1) ? 1 : (expA > 254) ? 254 : expA);
            end
        endcase
        if ($urandom % 2)
        begin
            swap = a;
            a    = b;
            b    = swap;
        end
    endtask

    initial
    begin
        void'($urandom(7));
        rstN  = 1'b0;
        start = 1'b0;
        opA   = '0;
        opB   = '0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < numOps; i++)
        begin
            pickOperands(nextA, nextB);
            modelAdd(nextA, nextB, expWord, expLatency);
            monitor.pushExpected(expWord, expLatency);
            @(posedge clk);
            start <= 1'b1;
            opA   <= nextA;
            opB   <= nextB;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            while (!done)
                @(negedge clk);
        end
        // Let the last result reach the checker
        repeat (2) @(negedge clk);
        monitor.finalReport(DUT.asserts.violations, totalErrors);
        if (totalErrors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Each operation needs far fewer cycles than its share here
    initial
    begin
        #((numOps * cyclesPerOp + resetCycles) * clockPeriod);
        $display("ERROR: watchdog expired before all operations finished");
        monitor.finalReport(DUT.asserts.violations, totalErrors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
fpPkg.sv
fpAddControl.sv
alignCounter.sv
alignShifter.sv
mantissaAdder.sv
normalize.sv
fpAdder.sv
fpAdder_asserts.sv
fpAdderChecker.sv
fpAdderTb.sv
